//--- verilog/MemPkg.sv
package MemPkg;

	// DRAM controller state, encoding follows the refresh sequence order
	typedef enum logic [2:0] {
		Idle         = 3'd0, // Ready for a RAM cycle or refresh
		Access       = 3'd1, // Column phase of a RAM cycle
		AccessEnd    = 3'd2, // RAS released, CAS held to cycle end
		CycleDone    = 3'd3, // Bus cycle complete
		RefRAS1      = 3'd4, // CBR refresh, CAS then RAS
		RefRAS2      = 3'd5, // RAS held, CAS released
		RefPrecharge = 3'd6, // RAS precharge
		RefDoneSt    = 3'd7  // Back to idle next
	} RAMState;

	// 68000 bus inputs, all strobes active low
	typedef struct packed {
		logic [23:1] A;   // Word address
		logic        nWE; // Low on write
		logic        nAS; // Address strobe
		logic        nLDS; // Lower byte strobe
		logic        nUDS; // Upper byte strobe
	} CPUBus;

	// DRAM pins
	typedef struct packed {
		logic [11:0] RA; // Multiplexed row/column address
		logic        nRAS;
		logic        nCAS;
		logic        nLWE; // Lower byte write
		logic        nUWE; // Upper byte write
		logic        nOE;
	} DRAMBus;

	// NOR flash strobes
	typedef struct packed {
		logic nROMOE;
		logic nROMWE;
	} ROMBus;

	// Region selects from the address decoder
	typedef struct packed {
		logic RAMCS;   // RAM region with AS low
		logic RAMCS0X; // RAM region from address only
		logic ROMCS;   // Flash region
		logic ROMCS4X; // Flash write window
	} Selects;

	localparam int RefCntW = 7; // Refresh counter width
	localparam logic [RefCntW-1:0] RefPeriod = 7'd96; // Clocks per refresh period
	localparam logic [RefCntW-1:0] RefUrgAt = 7'd64; // Count where refresh turns urgent
	localparam logic [1:0] IOWait = 2'd2; // I/O acknowledge delay in clocks

endpackage

//--- verilog/AddrDecode.sv
`timescale 1ns/1ps

module AddrDecode import MemPkg::*; (
	input  CPUBus  Bus,
	output Selects Sel
);

	logic RAMRegion; // A23:22 = 00
	logic ROMRegion; // A23:22 = 01
	logic ROMWrWin;  // A23:20 = 0100

	assign RAMRegion = (Bus.A[23:22] == 2'b00);
	assign ROMRegion = (Bus.A[23:22] == 2'b01);
	assign ROMWrWin  = (Bus.A[23:20] == 4'b0100); // Lowest 1MB of flash space

	// Address-only select, used by refresh arbitration
	assign Sel.RAMCS0X = RAMRegion;
	// Started RAM cycle, strobe qualified
	assign Sel.RAMCS   = RAMRegion && !Bus.nAS;
	assign Sel.ROMCS   = ROMRegion;
	assign Sel.ROMCS4X = ROMWrWin;

	// Anything outside RAM and ROM falls through as I/O,
	// which DTACKGen recognizes from RAMCS0X and ROMCS both low

endmodule

//--- verilog/CycleDetect.sv
`timescale 1ns/1ps

module CycleDetect (
	input  logic CLK,
	input  logic ROMReadyClear,
	input  logic nAS,
	output logic BACT,  // AS low, sampled
	output logic BACTr  // BACT one clock later
);

	// Bus strobe enters the clocked domain here only
	always_ff @(posedge CLK, posedge ROMReadyClear) begin
		if (ROMReadyClear) begin
			BACT  <= 1'b0;
			BACTr <= 1'b0;
		end else begin
			BACT  <= !nAS; // Cycle active level
			BACTr <= BACT; // History for first-clock detect
		end
	end

endmodule

//--- verilog/RefreshTimer.sv
`timescale 1ns/1ps

module RefreshTimer import MemPkg::*; (
	input  logic CLK,
	input  logic ROMReadyClear,
	output logic RefReq, // Low one clock at period start
	output logic RefUrg  // High late in the period
);

	logic [RefCntW-1:0] RefCnt; // Position within refresh period
	logic               PeriodEnd;

	assign PeriodEnd = (RefCnt == RefPeriod - 7'd1);

	// Modulo RefPeriod counter
	always_ff @(posedge CLK, posedge ROMReadyClear) begin
		if (ROMReadyClear) begin
			RefCnt <= '0;
		end else if (PeriodEnd) begin
			RefCnt <= '0; // Wrap, new period
		end else begin
			RefCnt <= RefCnt + 7'd1;
		end
	end

	// Low pulse at count 0 clears the controller's done flag,
	// high for the rest of the period opens the request window
	assign RefReq = (RefCnt != '0);

	// Urgent once the free slot has not come by RefUrgAt
	assign RefUrg = (RefCnt >= RefUrgAt);

endmodule

//--- verilog/RAM.sv
`timescale 1ns/1ps

module RAM import MemPkg::*; (
	input  logic   CLK,
	input  logic   ROMReadyClear,
	input  CPUBus  Bus,
	input  logic   BACT,
	input  logic   BACTr,
	input  Selects Sel,
	input  logic   nDTACK,
	input  logic   RAMWS,
	input  logic   ROMWS,
	input  logic   RefReqIn,
	input  logic   RefUrgIn,
	output logic   RAMReady,
	output logic   ROMReady,
	output DRAMBus DRAM,
	output ROMBus  ROM
);

	RAMState State;    // Controller state
	logic    RASEN;    // CPU RAS enable
	logic    RASEL;    // Column address select
	logic    RASrf;    // RAS hold, falling-edge stage
	logic    RefCAS;   // Refresh CAS strobe
	logic    CASEndEN; // Allow CAS release on AS high
	logic    CASEnd;
	logic    nCASq;    // CAS register
	logic    RefDone;  // Refresh done this period
	logic    RefReq;
	logic    RefUrg;
	logic    RS0toRef; // Idle decision: refresh
	logic    RS0toRAM; // Idle decision: RAM cycle
	logic    ROMWaitClear;
	logic [11:0] RowAddr;
	logic [11:0] ColAddr;

	// One refresh per period, flag dropped by the RefReq low pulse
	always_ff @(posedge CLK, posedge ROMReadyClear) begin
		if (ROMReadyClear) RefDone <= 1'b0;
		else if (!RefReqIn) RefDone <= 1'b0;
		else if (State == RefRAS1) RefDone <= 1'b1;
	end
	assign RefReq = RefReqIn && !RefDone;
	assign RefUrg = RefUrgIn && !RefDone;

	// DRAM strobes
	assign DRAM.nRAS = !((!Bus.nAS && Sel.RAMCS && RASEN) || RASrf);
	assign DRAM.nCAS = nCASq;
	assign DRAM.nLWE = !(!Bus.nLDS && RASEL && !Bus.nWE); // Only with column out
	assign DRAM.nUWE = !(!Bus.nUDS && RASEL && !Bus.nWE);
	assign DRAM.nOE  = 1'b0; // DRAM drives on CAS alone

	// Flash strobes, straight from the bus
	assign ROM.nROMOE = !(!Bus.nAS && Sel.ROMCS && Bus.nWE);
	assign ROM.nROMWE = !(!Bus.nAS && Sel.ROMCS4X && !Bus.nWE);

	// Flash wait state: cleared between cycles when ROMWS high
	assign ROMWaitClear = ROMWS && Bus.nAS;
	always_ff @(posedge CLK, posedge ROMReadyClear, posedge ROMWaitClear) begin
		if (ROMReadyClear) ROMReady <= 1'b0;
		else if (ROMWaitClear) ROMReady <= 1'b0;
		else ROMReady <= 1'b1; // First edge after clear
	end

	// Row address
	assign RowAddr[11]  = Bus.A[19]; // Same as RA3
	assign RowAddr[10]  = Bus.A[17];
	assign RowAddr[9]   = Bus.A[15];
	assign RowAddr[8]   = Bus.A[18];
	assign RowAddr[7:4] = Bus.A[14:11];
	assign RowAddr[3]   = Bus.A[19];
	assign RowAddr[2]   = Bus.A[16];
	assign RowAddr[1]   = Bus.A[10];
	assign RowAddr[0]   = Bus.A[9];

	// Column address
	assign ColAddr[11]  = Bus.A[20]; // Paired with RA3
	assign ColAddr[10]  = Bus.A[7];  // Row-only pin, column copy of RA2
	assign ColAddr[9]   = Bus.A[8];
	assign ColAddr[8]   = Bus.A[21];
	assign ColAddr[7:4] = Bus.A[6:3];
	assign ColAddr[3]   = Bus.A[20];
	assign ColAddr[2]   = Bus.A[7];
	assign ColAddr[1]   = Bus.A[2];
	assign ColAddr[0]   = Bus.A[1];

	assign DRAM.RA = RASEL ? ColAddr : RowAddr;

	// Refresh arbitration against CPU
	assign RS0toRef = (RefReq && BACT && !BACTr && !Sel.RAMCS0X) || // First clock, non-RAM
		(RefUrg && !BACT) ||                                     // Urgent, bus idle
		(RefUrg && BACT && !Sel.RAMCS0X);                        // Urgent, busy elsewhere
	assign RS0toRAM = BACT && Sel.RAMCS;

	// Main FSM, rising edge
	always_ff @(posedge CLK, posedge ROMReadyClear) begin
		if (ROMReadyClear) begin
			State    <= Idle;
			RAMReady <= 1'b0;
			RASEL    <= 1'b0;
			RefCAS   <= 1'b0;
			RASEN    <= 1'b0;
		end else begin
			RASEL  <= 1'b0; // Row unless overridden
			RefCAS <= 1'b0;
			case (State)
				Idle: begin
					if (RS0toRAM && RAMReady) begin // Start column phase
						State    <= Access;
						RAMReady <= 1'b1;
						RASEL    <= 1'b1;
						RASEN    <= 1'b1;
					end else if (RS0toRAM) begin // One wait state
						State    <= Idle;
						RAMReady <= 1'b1;
						RASEN    <= 1'b1;
					end else if (RS0toRef) begin // CBR refresh
						State    <= RefRAS1;
						RAMReady <= 1'b0;
						RefCAS   <= 1'b1;
						RASEN    <= 1'b0;
					end else begin
						State    <= Idle;
						RAMReady <= !RAMWS; // Pre-ready if no wait state
						RASEN    <= 1'b1;
					end
				end
				Access: begin
					if (!nDTACK || !BACT) State <= AccessEnd;
					else State <= Access; // Held by CPU
					RAMReady <= 1'b1;
					RASEL    <= 1'b1;
					RASEN    <= nDTACK;
				end
				AccessEnd: begin
					State    <= CycleDone;
					RAMReady <= 1'b1;
					RASEN    <= 1'b0;
				end
				CycleDone: begin
					if (RefUrg) begin // Overdue, refresh now
						State    <= RefRAS1;
						RAMReady <= 1'b0;
						RefCAS   <= 1'b1;
						RASEN    <= 1'b0;
					end else begin
						State    <= Idle;
						RAMReady <= !RAMWS;
						RASEN    <= 1'b1;
					end
				end
				RefRAS1: begin
					State    <= RefRAS2;
					RAMReady <= 1'b0;
					RASEN    <= 1'b0;
				end
				RefRAS2: begin
					State    <= RefPrecharge;
					RAMReady <= 1'b0;
					RASEN    <= 1'b0;
				end
				RefPrecharge: begin
					State    <= RefDoneSt;
					RAMReady <= 1'b0;
					RASEN    <= 1'b0;
				end
				RefDoneSt: begin // Reenable CPU access
					State    <= Idle;
					RAMReady <= !RAMWS;
					RASEN    <= 1'b1;
				end
			endcase
		end
	end

	// Falling-edge stage, RAS hold and CAS-end enable
	always_ff @(negedge CLK, posedge ROMReadyClear) begin
		if (ROMReadyClear) begin
			RASrf    <= 1'b0;
			CASEndEN <= 1'b0;
		end else begin
			case (State)
				Access: begin
					RASrf    <= 1'b1;
					CASEndEN <= 1'b1;
				end
				AccessEnd: begin
					RASrf    <= 1'b0;
					CASEndEN <= 1'b1;
				end
				RefRAS1, RefRAS2: begin // Refresh RAS low
					RASrf    <= 1'b1;
					CASEndEN <= 1'b0;
				end
				default: begin
					RASrf    <= 1'b0;
					CASEndEN <= 1'b0;
				end
			endcase
		end
	end

	// CAS: async set by refresh, async release at cycle end
	assign CASEnd = CASEndEN && Bus.nAS;
	always_ff @(negedge CLK, posedge ROMReadyClear, posedge RefCAS, posedge CASEnd) begin
		if (ROMReadyClear) nCASq <= 1'b1;
		else if (RefCAS) nCASq <= 1'b0; // CAS before RAS
		else if (CASEnd) nCASq <= 1'b1;
		else begin
			case (State)
				Access, AccessEnd, RefRAS1: nCASq <= 1'b0;
				default: nCASq <= 1'b1;
			endcase
		end
	end

endmodule

//--- verilog/DTACKGen.sv
`timescale 1ns/1ps

module DTACKGen import MemPkg::*; (
	input  logic   CLK,
	input  logic   ROMReadyClear,
	input  logic   nAS,
	input  Selects Sel,
	input  logic   RAMReady,
	input  logic   ROMReady,
	output logic   nDTACK
);

	logic [1:0] IOCnt;   // Clocks of AS low
	logic       IORegion; // Neither RAM nor ROM
	logic       IODone;

	// Wait counter, saturates at IOWait
	always_ff @(posedge CLK, posedge ROMReadyClear) begin
		if (ROMReadyClear) IOCnt <= '0;
		else if (nAS) IOCnt <= '0; // Restart each cycle
		else if (IOCnt != IOWait) IOCnt <= IOCnt + 2'd1;
	end

	assign IORegion = !Sel.RAMCS0X && !Sel.ROMCS;
	assign IODone   = (IOCnt == IOWait);

	assign nDTACK = !(!nAS && ((Sel.RAMCS && RAMReady) || // RAM ready
		(Sel.ROMCS && ROMReady) ||                        // Flash ready
		(IORegion && IODone)));                           // I/O after delay

endmodule

//--- verilog/MemTop.sv
`timescale 1ns/1ps

module MemTop import MemPkg::*; (
	input  logic   CLK,
	input  logic   ROMReadyClear,
	input  CPUBus  Bus,
	input  logic   RAMWS,
	input  logic   ROMWS,
	output DRAMBus DRAM,
	output ROMBus  ROM,
	output logic   nDTACK
);

	Selects Sel;      // Region decode
	logic   BACT;     // Cycle active
	logic   BACTr;    // Cycle active, delayed
	logic   RefReq;
	logic   RefUrg;
	logic   RAMReady;
	logic   ROMReady;

	AddrDecode uDecode (
		.Bus (Bus),
		.Sel (Sel)
	);

	CycleDetect uCycle (
		.CLK           (CLK),
		.ROMReadyClear (ROMReadyClear),
		.nAS           (Bus.nAS),
		.BACT          (BACT),
		.BACTr         (BACTr)
	);

	RefreshTimer uRefresh (
		.CLK           (CLK),
		.ROMReadyClear (ROMReadyClear),
		.RefReq        (RefReq),
		.RefUrg        (RefUrg)
	);

	RAM uRAM (
		.CLK           (CLK),
		.ROMReadyClear (ROMReadyClear),
		.Bus           (Bus),
		.BACT          (BACT),
		.BACTr         (BACTr),
		.Sel           (Sel),
		.nDTACK        (nDTACK), // Ends the access state
		.RAMWS         (RAMWS),
		.ROMWS         (ROMWS),
		.RefReqIn      (RefReq),
		.RefUrgIn      (RefUrg),
		.RAMReady      (RAMReady),
		.ROMReady      (ROMReady),
		.DRAM          (DRAM),
		.ROM           (ROM)
	);

	DTACKGen uDTACK (
		.CLK           (CLK),
		.ROMReadyClear (ROMReadyClear),
		.nAS           (Bus.nAS),
		.Sel           (Sel),
		.RAMReady      (RAMReady),
		.ROMReady      (ROMReady),
		.nDTACK        (nDTACK)
	);

endmodule

//--- tb/ClockGen.sv
`timescale 1ns/1ps

module ClockGen (
	output logic CLK,
	output logic ROMReadyClear
);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK; // 10 ns period
	end

	// Reset held for the first 10 rising edges
	initial begin
		ROMReadyClear = 1'b1;
		repeat (10) @(posedge CLK);
		ROMReadyClear <= 1'b0;
	end

endmodule

//--- tb/MemCheck.sv
`timescale 1ns/1ps

module MemCheck import MemPkg::*; (
	input  logic   CLK,
	input  logic   ROMReadyClear,
	input  CPUBus  Bus,
	input  logic   ROMWS,
	input  DRAMBus DRAM,
	input  ROMBus  ROM,
	input  logic   nDTACK,
	output int     ErrCnt
);

	int         PinErr = 0;   // Strobe and acknowledge rules
	int         RowErr = 0;
	int         ColErr = 0;
	int         RefErr = 0;
	int         CBRTotal = 0; // CAS-before-RAS seen so far
	int         CBRMark = 0;  // Total at last period start
	int         Periods = 0;
	int         LowClks = 0;  // Falling edges with AS low
	logic       Started = 1'b0;
	logic       CBRPend = 1'b0; // CAS fell with RAS high
	logic [6:0] RefCnt;       // Mirrors the refresh period
	logic       nRAS;
	logic       nCAS;
	logic       InRAM;
	logic       InIO;

	assign nRAS   = DRAM.nRAS;
	assign nCAS   = DRAM.nCAS;
	assign InRAM  = (Bus.A[23:22] == 2'b00);
	assign InIO   = Bus.A[23];
	assign ErrCnt = PinErr + RowErr + ColErr + RefErr;

	function automatic logic [11:0] rowMap(logic [23:1] A);
		return {A[19], A[17], A[15], A[18], A[14:11], A[19], A[16], A[10], A[9]};
	endfunction

	function automatic logic [11:0] colMap(logic [23:1] A);
		return {A[20], A[7], A[8], A[21], A[6:3], A[20], A[7], A[2], A[1]};
	endfunction

	task automatic showError(string Name, logic [11:0] Exp, logic [11:0] Act);
		$display("Error at %0t: %s expected %h, got %h", $time, Name, Exp, Act);
	endtask

	// Level rules sampled mid-clock
	always @(negedge CLK) begin
		LowClks = Bus.nAS ? 0 : LowClks + 1;
		if (ROMReadyClear || (!Started && Bus.nAS)) begin
			if ({nRAS, nCAS, DRAM.nLWE, DRAM.nUWE, ROM, nDTACK} != 7'h7F) begin
				showError("idle strobes", 12'h7F, {nRAS, nCAS, DRAM.nLWE, DRAM.nUWE, ROM, nDTACK});
				PinErr++;
			end
		end
		if (!ROMReadyClear && !Bus.nAS) Started = 1'b1;
		if (DRAM.nOE !== 1'b0) begin // DRAM output enable tied active
			showError("nOE", 1'b0, DRAM.nOE);
			PinErr++;
		end
		if (ROM.nROMOE != !(!Bus.nAS && Bus.A[23:22] == 2'b01 && Bus.nWE)) begin
			showError("nROMOE", !ROM.nROMOE, ROM.nROMOE);
			PinErr++;
		end
		if (ROM.nROMWE != !(!Bus.nAS && Bus.A[23:20] == 4'b0100 && !Bus.nWE)) begin
			showError("nROMWE", !ROM.nROMWE, ROM.nROMWE);
			PinErr++;
		end
		// Byte writes need a RAM write with column out
		if (!DRAM.nLWE && (Bus.nWE || Bus.nLDS || !InRAM || DRAM.RA != colMap(Bus.A))) begin
			showError("nLWE", 1'b1, 1'b0);
			PinErr++;
		end
		if (!DRAM.nUWE && (Bus.nWE || Bus.nUDS || !InRAM || DRAM.RA != colMap(Bus.A))) begin
			showError("nUWE", 1'b1, 1'b0);
			PinErr++;
		end
		if (!nDTACK && (Bus.nAS || (LowClks == 1 && !InRAM && !InIO && ROMWS) ||
			(InIO && LowClks <= IOWait))) begin // Too early
			showError("nDTACK", 1'b1, 1'b0);
			PinErr++;
		end
	end

	// Row address, and the RAS half of a CBR refresh
	always @(negedge nRAS) begin
		#1;
		if (CBRPend) begin
			if (!nCAS) CBRTotal++; // RAS followed the refresh CAS
			CBRPend = 1'b0;
		end
		if (!nRAS && nCAS && !Bus.nAS && InRAM && DRAM.RA != rowMap(Bus.A)) begin
			showError("RA row", rowMap(Bus.A), DRAM.RA);
			RowErr++;
		end
	end

	// Column address or the CAS half of a CBR refresh
	always @(negedge nCAS) begin
		#1;
		if (!nCAS && nRAS && !ROMReadyClear) CBRPend = 1'b1; // RAS must fall next
		else if (!nCAS && !nRAS && !Bus.nAS && InRAM && DRAM.RA != colMap(Bus.A)) begin
			showError("RA column", colMap(Bus.A), DRAM.RA);
			ColErr++;
		end
	end

	// Period tally at each wrap from the second period on
	always @(posedge CLK, posedge ROMReadyClear) begin
		if (ROMReadyClear) begin
			RefCnt = '0;
			Periods = 0;
		end else begin
			if (RefCnt == '0) begin
				if (Periods >= 2 && CBRTotal - CBRMark != 1) begin
					$display("Error at %0t: refresh period had %0d CBR cycles instead of one",
						$time, CBRTotal - CBRMark);
					RefErr++;
				end
				CBRMark = CBRTotal;
				Periods++;
			end
			RefCnt = (RefCnt == RefPeriod - 7'd1) ? '0 : RefCnt + 7'd1;
		end
	end

endmodule

//--- tb/MemTb.sv
`timescale 1ns/1ps

module MemTb import MemPkg::*; ();

	logic   CLK;
	logic   ROMReadyClear;
	CPUBus  Bus;
	logic   RAMWS;
	logic   ROMWS;
	DRAMBus DRAM;
	ROMBus  ROM;
	logic   nDTACK;
	int     ErrCnt;
	int     NumCycles = 400;
	int     MaxCycleClks = 30; // Gap, refresh stretch and wait states
	int     CyclesDone = 0;

	ClockGen uClk (.CLK(CLK), .ROMReadyClear(ROMReadyClear));

	MemTop UUT (
		.CLK           (CLK),
		.ROMReadyClear (ROMReadyClear),
		.Bus           (Bus),
		.RAMWS         (RAMWS),
		.ROMWS         (ROMWS),
		.DRAM          (DRAM),
		.ROM           (ROM),
		.nDTACK        (nDTACK)
	);

	MemCheck uCheck (
		.CLK(CLK), .ROMReadyClear(ROMReadyClear), .Bus(Bus), .ROMWS(ROMWS),
		.DRAM(DRAM), .ROM(ROM), .nDTACK(nDTACK), .ErrCnt(ErrCnt)
	);

	// One 68000 bus cycle with a random idle gap in front
	task automatic driveCycle();
		logic [23:1] Addr;
		logic [1:0]  Region;
		logic [1:0]  Bytes;
		Addr   = $urandom;
		Region = $urandom % 4;
		Bytes  = $urandom % 3; // Never both strobes high
		Addr[23:22] = Region; // 00 RAM, 01 flash, else I/O
		@(posedge CLK);
		RAMWS <= $urandom % 2; // Settle wait states before AS
		ROMWS <= $urandom % 2;
		repeat (2 + $urandom % 6) @(posedge CLK);
		Bus <= '{A: Addr, nWE: $urandom % 2, nAS: 1'b0, nLDS: Bytes[0], nUDS: Bytes[1]};
		do @(posedge CLK); while (nDTACK); // Wait for acknowledge
		@(posedge CLK);
		Bus.nAS <= 1'b1; // Address and strobes held into the gap
	endtask

	initial begin
		void'($urandom(16472));
		Bus   = '{A: '0, nWE: 1'b1, nAS: 1'b1, nLDS: 1'b1, nUDS: 1'b1};
		RAMWS = 1'b0;
		ROMWS = 1'b1;
		wait (!ROMReadyClear);
		repeat (NumCycles) begin
			driveCycle();
			CyclesDone++;
		end
		repeat (4) @(posedge CLK);
		$display("%0d bus cycles, %0d errors", CyclesDone, ErrCnt);
		if (ErrCnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog, a stuck acknowledge ends the run here
	initial begin
		#((NumCycles * MaxCycleClks + 200) * 10);
		$display("Timeout, bus cycle %0d never got its acknowledge", CyclesDone);
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- files.f
verilog/MemPkg.sv
verilog/AddrDecode.sv
verilog/CycleDetect.sv
verilog/RefreshTimer.sv
verilog/RAM.sv
verilog/DTACKGen.sv
verilog/MemTop.sv
tb/ClockGen.sv
tb/MemCheck.sv
tb/MemTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module MemTb -f files.f -o MemSim
./obj_dir/MemSim > sim.log 2>&1
cat sim.log
if grep -q "Test FAILED" sim.log; then
	exit 1
fi
